// File: logic/bpred_pkg.sv
`default_nettype none

package bpred_pkg;

    localparam int ADDR_W       = 32;
    localparam int BTB_IDX_W    = 4;
    localparam int BTB_TAG_W    = ADDR_W - BTB_IDX_W - 2;  // PC bits 31..6
    localparam int LHT_IDX_W    = 4;  // Local history table index, PC bits 5..2
    localparam int LHIST_W      = 4;
    localparam int GHIST_W      = 6;
    localparam int CHOICE_IDX_W = 4;

    localparam logic [1:0] CTR_RESET = 2'b01;  // Weakly not taken

    // MIPS opcodes of interest
    localparam logic [5:0] OP_J    = 6'h02;
    localparam logic [5:0] OP_JAL  = 6'h03;
    localparam logic [5:0] OP_BEQ  = 6'h04;
    localparam logic [5:0] OP_BNE  = 6'h05;
    localparam logic [5:0] OP_BLEZ = 6'h06;
    localparam logic [5:0] OP_BGTZ = 6'h07;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] offset;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fmt_t;

    // One instruction word seen as I-format or J-format
    typedef union packed {
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [1:0] {
        CLS_NONE   = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JUMP   = 2'd2
    } instr_class_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        instr_u            instr;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        instr_u            instr;
        logic              taken;
        logic [ADDR_W-1:0] target;
        logic [1:0]        preds;  // [1] global, [0] local
    } resolve_t;

    typedef struct packed {
        logic              valid;
        logic              taken;
        logic [ADDR_W-1:0] target;
        logic [1:0]        preds;
    } pred_t;

    typedef struct packed {
        instr_class_t      cls;
        logic [ADDR_W-1:0] pc;
        logic              taken;
        logic [ADDR_W-1:0] target;
        logic [1:0]        preds;
    } update_t;

    // Saturating two-bit counter step
    function automatic logic [1:0] ctr_next(input logic [1:0] ctr, input logic up);
        logic [1:0] nxt;
        nxt = ctr;
        if (up && ctr != 2'b11) begin
            nxt = ctr + 2'd1;
        end else if (!up && ctr != 2'b00) begin
            nxt = ctr - 2'd1;
        end
        return nxt;
    endfunction

endpackage

`default_nettype wire

// File: logic/branch_classifier.sv
`default_nettype none

module branch_classifier (
    input  bpred_pkg::instr_u             instr,
    input  logic [bpred_pkg::ADDR_W-1:0]  pc,
    output bpred_pkg::instr_class_t       cls,
    output logic [bpred_pkg::ADDR_W-1:0]  target
);
    import bpred_pkg::*;

    logic [ADDR_W-1:0] pc_plus4;
    logic [ADDR_W-1:0] br_offset;
    logic [ADDR_W-1:0] br_target;
    logic [ADDR_W-1:0] jmp_target;

    assign pc_plus4 = pc + ADDR_W'(4);

    // Sign-extended word offset
    assign br_offset  = {{(ADDR_W-18){instr.i.offset[15]}}, instr.i.offset, 2'b00};
    assign br_target  = pc_plus4 + br_offset;
    assign jmp_target = {pc_plus4[ADDR_W-1:ADDR_W-4], instr.j.index, 2'b00};  // Region jump

    always_comb begin
        case (instr.i.opcode)
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                cls    = CLS_BRANCH;
                target = br_target;
            end
            OP_J, OP_JAL: begin
                cls    = CLS_JUMP;
                target = jmp_target;
            end
            default: begin
                cls    = CLS_NONE;
                target = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/branch_target_buffer.sv
`default_nettype none

module branch_target_buffer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [bpred_pkg::ADDR_W-1:0]  lookup_pc,
    input  bpred_pkg::update_t            upd,
    output logic                          hit,
    output logic [bpred_pkg::ADDR_W-1:0]  target
);
    import bpred_pkg::*;

    localparam int ENTRIES = 1 << BTB_IDX_W;

    logic                 valid_q  [ENTRIES];
    logic [BTB_TAG_W-1:0] tag_q    [ENTRIES];
    logic [ADDR_W-1:0]    target_q [ENTRIES];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_TAG_W-1:0] rd_tag;
    logic [BTB_IDX_W-1:0] wr_idx;
    logic [BTB_TAG_W-1:0] wr_tag;
    logic                 wr_en;
    logic                 inval_en;

    assign rd_idx = lookup_pc[BTB_IDX_W+1:2];
    assign rd_tag = lookup_pc[ADDR_W-1:BTB_IDX_W+2];
    assign wr_idx = upd.pc[BTB_IDX_W+1:2];
    assign wr_tag = upd.pc[ADDR_W-1:BTB_IDX_W+2];

    // Lookup
    assign hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target = hit ? target_q[rd_idx] : '0;

    // Any taken branch or jump allocates
    assign wr_en = (upd.cls != CLS_NONE) && upd.taken;

    // A not-taken branch drops its own entry only
    assign inval_en = (upd.cls == CLS_BRANCH) && !upd.taken
                      && valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end else if (inval_en) begin
            valid_q[wr_idx] <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.target;
        end
    end

endmodule

`default_nettype wire

// File: logic/local_predictor.sv
`default_nettype none

module local_predictor (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [bpred_pkg::ADDR_W-1:0]  lookup_pc,
    input  bpred_pkg::update_t            upd,
    output logic                          taken
);
    import bpred_pkg::*;

    localparam int LHT_ENTRIES = 1 << LHT_IDX_W;
    localparam int CTR_ENTRIES = 1 << LHIST_W;

    logic [LHIST_W-1:0] hist_q [LHT_ENTRIES];  // Per-branch outcome history
    logic [1:0]         ctr_q  [CTR_ENTRIES];  // Shared pattern table

    logic [LHT_IDX_W-1:0] rd_idx;
    logic [LHT_IDX_W-1:0] wr_idx;
    logic [LHIST_W-1:0]   rd_hist;
    logic [LHIST_W-1:0]   wr_hist;
    logic                 upd_en;

    assign rd_idx  = lookup_pc[LHT_IDX_W+1:2];
    assign rd_hist = hist_q[rd_idx];
    assign taken   = ctr_q[rd_hist][1];

    assign wr_idx  = upd.pc[LHT_IDX_W+1:2];
    assign wr_hist = hist_q[wr_idx];
    assign upd_en  = (upd.cls == CLS_BRANCH);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < LHT_ENTRIES; i++) begin
                hist_q[i] <= '0;
            end
            for (int i = 0; i < CTR_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (upd_en) begin
            // Train with the history seen before this outcome
            ctr_q[wr_hist] <= ctr_next(ctr_q[wr_hist], upd.taken);
            hist_q[wr_idx] <= {wr_hist[LHIST_W-2:0], upd.taken};
        end
    end

endmodule

`default_nettype wire

// File: logic/global_predictor.sv
`default_nettype none

module global_predictor (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [bpred_pkg::ADDR_W-1:0]  lookup_pc,
    input  bpred_pkg::update_t            upd,
    output logic                          taken
);
    import bpred_pkg::*;

    localparam int CTR_ENTRIES = 1 << GHIST_W;

    logic [GHIST_W-1:0] ghist_q;
    logic [1:0]         ctr_q [CTR_ENTRIES];

    logic [GHIST_W-1:0] rd_idx;
    logic [GHIST_W-1:0] wr_idx;
    logic               upd_en;

    // gshare hashing
    assign rd_idx = ghist_q ^ lookup_pc[GHIST_W+1:2];
    assign wr_idx = ghist_q ^ upd.pc[GHIST_W+1:2];
    assign taken  = ctr_q[rd_idx][1];
    assign upd_en = (upd.cls == CLS_BRANCH);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            ghist_q <= '0;
            for (int i = 0; i < CTR_ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (upd_en) begin
            ctr_q[wr_idx] <= ctr_next(ctr_q[wr_idx], upd.taken);  // Old history index
            ghist_q       <= {ghist_q[GHIST_W-2:0], upd.taken};
        end
    end

endmodule

`default_nettype wire

// File: logic/choice_predictor.sv
`default_nettype none

module choice_predictor (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic [bpred_pkg::ADDR_W-1:0]  lookup_pc,
    input  bpred_pkg::update_t            upd,
    output logic                          use_global
);
    import bpred_pkg::*;

    localparam int ENTRIES = 1 << CHOICE_IDX_W;

    logic [1:0] ctr_q [ENTRIES];  // 2 or above selects global

    logic [CHOICE_IDX_W-1:0] rd_idx;
    logic [CHOICE_IDX_W-1:0] wr_idx;
    logic                    disagree;
    logic                    global_right;
    logic                    upd_en;

    assign rd_idx     = lookup_pc[CHOICE_IDX_W+1:2];
    assign use_global = ctr_q[rd_idx][1];

    assign wr_idx       = upd.pc[CHOICE_IDX_W+1:2];
    assign disagree     = upd.preds[1] ^ upd.preds[0];
    assign global_right = (upd.preds[1] == upd.taken);

    // Only a disagreement says anything about which component is better
    assign upd_en = (upd.cls == CLS_BRANCH) && disagree;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < ENTRIES; i++) begin
                ctr_q[i] <= CTR_RESET;
            end
        end else if (upd_en) begin
            ctr_q[wr_idx] <= ctr_next(ctr_q[wr_idx], global_right);
        end
    end

endmodule

`default_nettype wire

// File: logic/hybrid_predictor.sv
`default_nettype none

module hybrid_predictor (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 FLUSH,
    input  bpred_pkg::fetch_t    fetch,
    input  bpred_pkg::resolve_t  resolve,
    output bpred_pkg::pred_t     pred
);
    import bpred_pkg::*;

    instr_class_t fet_cls;
    instr_class_t res_cls;
    update_t      upd;
    pred_t        pred_d;

    logic              btb_hit;
    logic [ADDR_W-1:0] btb_target;
    logic              local_taken;
    logic              global_taken;
    logic              use_global;
    logic              chosen_taken;

    branch_classifier fetch_cls_inst (
        .instr  (fetch.instr),
        .pc     (fetch.pc),
        .cls    (fet_cls),
        .target ()
    );

    branch_classifier resolve_cls_inst (
        .instr  (resolve.instr),
        .pc     (resolve.pc),
        .cls    (res_cls),
        .target ()
    );

    // Classified resolution stays idle unless strobed
    always_comb begin
        upd.cls    = resolve.valid ? res_cls : CLS_NONE;
        upd.pc     = resolve.pc;
        upd.taken  = resolve.taken;
        upd.target = resolve.target;
        upd.preds  = resolve.preds;
    end

    branch_target_buffer btb_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .lookup_pc (fetch.pc),
        .upd       (upd),
        .hit       (btb_hit),
        .target    (btb_target)
    );

    local_predictor local_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .lookup_pc (fetch.pc),
        .upd       (upd),
        .taken     (local_taken)
    );

    global_predictor global_inst (
        .CLK       (CLK),
        .RESET     (RESET),
        .lookup_pc (fetch.pc),
        .upd       (upd),
        .taken     (global_taken)
    );

    choice_predictor choice_inst (
        .CLK        (CLK),
        .RESET      (RESET),
        .lookup_pc  (fetch.pc),
        .upd        (upd),
        .use_global (use_global)
    );

    assign chosen_taken = use_global ? global_taken : local_taken;

    always_comb begin
        pred_d.valid  = fetch.valid;
        // Jumps need only a BTB hit and branches also need the chosen direction
        pred_d.taken  = fetch.valid && btb_hit && (fet_cls != CLS_NONE)
                        && ((fet_cls == CLS_JUMP) || chosen_taken);
        pred_d.target = btb_target;  // Zero on a miss
        pred_d.preds  = {global_taken, local_taken};
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pred <= '0;
        end else if (FLUSH) begin
            pred <= '0;  // Drop the fetch of this cycle
        end else begin
            pred <= pred_d;
        end
    end

endmodule

`default_nettype wire

// File: testbench/hybrid_predictor_props.sv
`default_nettype none

module hybrid_predictor_props (
    input logic             CLK,
    input logic             RESET,
    input logic             FLUSH,
    input logic             fetch_valid,
    input logic             btb_hit,
    input bpred_pkg::pred_t pred
);
    int fails = 0;  // Failed assertion count

    // A prediction only follows an unflushed fetch out of reset
    a_valid_after_fetch: assert property (@(posedge CLK) disable iff (!RESET)
        pred.valid |-> $past(fetch_valid && !FLUSH && RESET))
    else begin
        fails++;
        $error("pred.valid without a preceding unflushed fetch");
    end

    a_fetch_gives_valid: assert property (@(posedge CLK) disable iff (!RESET)
        fetch_valid && !FLUSH |=> pred.valid)
    else begin
        fails++;
        $error("fetch strobe produced no prediction");
    end

    a_taken_is_valid: assert property (@(posedge CLK) disable iff (!RESET)
        pred.taken |-> pred.valid)
    else begin
        fails++;
        $error("pred.taken high while pred.valid low");
    end

    // BTB miss on the lookup that built this prediction
    a_miss_zero_target: assert property (@(posedge CLK) disable iff (!RESET)
        !pred.taken && !$past(btb_hit) |-> pred.target == '0)
    else begin
        fails++;
        $error("nonzero pred.target after a BTB miss");
    end

endmodule

`default_nettype wire

// File: testbench/hybrid_predictor_tb.sv
`default_nettype none

module hybrid_predictor_tb;
    import bpred_pkg::*;

    localparam int FILLER_COUNT = 32;
    localparam int DO_FETCH     = 0;
    localparam int DO_RESOLVE   = 1;
    localparam int DO_FLUSH     = 2;  // FLUSH together with a fetch

    localparam logic [31:0] BEQ_WORD  = 32'h1022_0010;  // beq r1,r2 from 0x1000 to 0x1044
    localparam logic [31:0] BNE_WORD  = 32'h1464_FFFE;  // bne r3,r4 from 0x1008 to 0x1004
    localparam logic [31:0] BLEZ_WORD = 32'h18A0_0004;  // blez r5 from 0x1014 to 0x1028
    localparam logic [31:0] J_WORD    = 32'h0800_0C00;  // j 0x3000
    localparam logic [31:0] JAL_WORD  = 32'h0C00_0C00;  // jal 0x3000

    logic     CLK;
    logic     RESET;
    logic     FLUSH;
    fetch_t   fetch;
    resolve_t resolve;
    pred_t    pred;

    // Stimulus table; on fetch rows the last three columns hold the expected prediction
    string       names   [$];
    int          ops     [$];
    logic [31:0] pcs     [$];
    logic [31:0] words   [$];
    logic        takens  [$];
    logic [31:0] targets [$];
    logic [1:0]  predss  [$];

    int          checks;
    int          errors;
    logic [31:0] rng;

    hybrid_predictor hybrid_predictor_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .FLUSH   (FLUSH),
        .fetch   (fetch),
        .resolve (resolve),
        .pred    (pred)
    );

    bind hybrid_predictor hybrid_predictor_props props_inst (
        .CLK         (CLK),
        .RESET       (RESET),
        .FLUSH       (FLUSH),
        .fetch_valid (fetch.valid),
        .btb_hit     (btb_hit),
        .pred        (pred)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic add_step(input string name, input int op, input logic [31:0] pc,
                            input logic [31:0] word, input logic tk,
                            input logic [31:0] tgt, input logic [1:0] prd);
        names.push_back(name);
        ops.push_back(op);
        pcs.push_back(pc);
        words.push_back(word);
        takens.push_back(tk);
        targets.push_back(tgt);
        predss.push_back(prd);
    endtask

    task automatic build_table();
        add_step("cold_beq", DO_FETCH, 32'h1000, BEQ_WORD, 1'b0, 32'h0, 2'b00);
        add_step("cold_bne", DO_FETCH, 32'h1008, BNE_WORD, 1'b0, 32'h0, 2'b00);
        add_step("cold_j", DO_FETCH, 32'h2010, J_WORD, 1'b0, 32'h0, 2'b00);
        add_step("train_j", DO_RESOLVE, 32'h2010, J_WORD, 1'b1, 32'h3000, 2'b00);
        add_step("j_hit", DO_FETCH, 32'h2010, J_WORD, 1'b1, 32'h3000, 2'b00);
        add_step("jal_alias", DO_FETCH, 32'h2410, JAL_WORD, 1'b0, 32'h0, 2'b00);
        // Taken beq interleaved with a not-taken bne so global history ends at 010101
        for (int k = 0; k < 6; k++) begin
            add_step($sformatf("local_beq_%0d", k), DO_RESOLVE, 32'h1000, BEQ_WORD,
                     1'b1, 32'h1044, 2'b00);
            if (k < 5) begin
                add_step($sformatf("local_bne_%0d", k), DO_RESOLVE, 32'h1008, BNE_WORD,
                         1'b0, 32'h100C, 2'b00);
            end
        end
        add_step("local_hit", DO_FETCH, 32'h1000, BEQ_WORD, 1'b1, 32'h1044, 2'b01);
        add_step("choice_1", DO_RESOLVE, 32'h1014, BLEZ_WORD, 1'b1, 32'h1028, 2'b10);
        add_step("choice_2", DO_RESOLVE, 32'h1014, BLEZ_WORD, 1'b1, 32'h1028, 2'b10);
        add_step("choice_global", DO_FETCH, 32'h1014, BLEZ_WORD, 1'b0, 32'h1028, 2'b01);
        // Agreeing taken bne would push its choice counter to global if it moved
        add_step("agree_1", DO_RESOLVE, 32'h1008, BNE_WORD, 1'b1, 32'h1004, 2'b11);
        add_step("agree_2", DO_RESOLVE, 32'h1008, BNE_WORD, 1'b1, 32'h1004, 2'b11);
        add_step("choice_kept", DO_FETCH, 32'h1008, BNE_WORD, 1'b1, 32'h1004, 2'b01);
        add_step("untrain_beq", DO_RESOLVE, 32'h1000, BEQ_WORD, 1'b0, 32'h1004, 2'b00);
        add_step("btb_dropped", DO_FETCH, 32'h1000, BEQ_WORD, 1'b0, 32'h0, 2'b00);
        add_step("flush_j", DO_FLUSH, 32'h2010, J_WORD, 1'b0, 32'h0, 2'b00);
        add_step("after_flush", DO_FETCH, 32'h2010, J_WORD, 1'b1, 32'h3000, 2'b01);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("CHECK FAILED %s: expected %0h, actual %0h", what, expected, actual);
    endtask

    task automatic apply_step(input string name, input int op, input logic [31:0] pc,
                              input logic [31:0] word, input logic tk,
                              input logic [31:0] tgt, input logic [1:0] prd);
        @(posedge CLK);
        #2;
        if (op == DO_RESOLVE) begin
            resolve.valid  = 1'b1;
            resolve.pc     = pc;
            resolve.instr  = word;
            resolve.taken  = tk;
            resolve.target = tgt;
            resolve.preds  = prd;
        end else begin
            fetch.valid = 1'b1;
            fetch.pc    = pc;
            fetch.instr = word;
            FLUSH       = (op == DO_FLUSH);
        end
        @(posedge CLK);
        #2;
        fetch.valid   = 1'b0;
        resolve.valid = 1'b0;
        FLUSH         = 1'b0;
        checks++;
        if (op == DO_FETCH) begin
            if (pred.valid !== 1'b1) report_mismatch({name, " valid"}, 1, pred.valid);
            if (pred.taken !== tk) report_mismatch({name, " taken"}, tk, pred.taken);
            if (pred.target !== tgt) report_mismatch({name, " target"}, tgt, pred.target);
            if (pred.preds !== prd) report_mismatch({name, " preds"}, prd, pred.preds);
        end else if (pred.valid !== 1'b0) begin
            report_mismatch({name, " valid"}, 0, pred.valid);  // No prediction expected
        end
    endtask

    initial begin : watchdog
        int limit;
        #1;
        limit = (names.size() + FILLER_COUNT) * 4 * 20 + 1000;
        #(limit);
        $display("Timeout: the run did not finish within %0d time units", limit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] fill_pc;
        logic [31:0] fill_word;
        RESET   = 1'b0;
        FLUSH   = 1'b0;
        fetch   = '0;
        resolve = '0;
        checks  = 0;
        errors  = 0;
        rng     = 32'd22781;
        build_table();
        repeat (10) @(posedge CLK);
        #2 RESET = 1'b1;
        // Non-branch ALU words at random word-aligned PCs on cold tables
        for (int n = 0; n < FILLER_COUNT; n++) begin
            rng       = xorshift(rng);
            fill_pc   = {rng[31:2], 2'b00};
            rng       = xorshift(rng);
            fill_word = {6'h00, rng[25:0]};
            apply_step($sformatf("filler_%0d", n), DO_FETCH, fill_pc, fill_word,
                       1'b0, 32'h0, 2'b00);
        end
        for (int i = 0; i < names.size(); i++) begin
            apply_step(names[i], ops[i], pcs[i], words[i], takens[i], targets[i], predss[i]);
        end
        $display("Steps checked: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, hybrid_predictor_inst.props_inst.fails);
        if (errors == 0 && hybrid_predictor_inst.props_inst.fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hybrid_predictor.f
logic/bpred_pkg.sv
logic/branch_classifier.sv
logic/branch_target_buffer.sv
logic/local_predictor.sv
logic/global_predictor.sv
logic/choice_predictor.sv
logic/hybrid_predictor.sv
testbench/hybrid_predictor_props.sv
testbench/hybrid_predictor_tb.sv

// File: Bender.yml
package:
  name: hybrid_predictor

sources:
  - files:
      - logic/bpred_pkg.sv
      - logic/branch_classifier.sv
      - logic/branch_target_buffer.sv
      - logic/local_predictor.sv
      - logic/global_predictor.sv
      - logic/choice_predictor.sv
      - logic/hybrid_predictor.sv
  - target: test
    files:
      - testbench/hybrid_predictor_props.sv
      - testbench/hybrid_predictor_tb.sv
